// ==== cpuPkg.sv ====
package cpuPkg;

	typedef logic [31:0] dataT;
	typedef logic [4:0] regAddrT;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSll,
		aluLui,
		aluNone
	} aluOpT;

	// Boot vector of the kseg1 ROM
	localparam dataT resetPc = 32'hBFC00000;

	// Primary opcodes
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opOri = 6'h0D;
	localparam logic [5:0] opLui = 6'h0F;

	// SPECIAL function codes
	localparam logic [5:0] fnSll = 6'h00;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnXor = 6'h26;
	localparam logic [5:0] fnSlt = 6'h2A;

	// Byte enables of a full-word register write
	localparam logic [3:0] wenAll = 4'b1111;

endpackage

// ==== tbProgram.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// Fibonacci LFSR with taps 16 14 13 11 and one step per bit
function automatic logic takeBit();
	logic fb;
	fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
	lfsr = {lfsr[14:0], fb};
	return fb;
endfunction

function automatic logic [15:0] takeBits(input int count);
	logic [15:0] value;
	value = '0;
	for (int i = 0; i < count; i++) begin
		value = {value[14:0], takeBit()};
	end
	return value;
endfunction

// Three picks out of four land in $0..$7
function automatic regAddrT pickReg();
	logic [15:0] sel;
	logic [15:0] num;
	sel = takeBits(2);
	if (sel[1:0] != 2'b00) begin
		num = takeBits(3);
	end else begin
		num = takeBits(5);
	end
	return num[4:0];
endfunction

function automatic dataT encodeR(input logic [5:0] fn, input regAddrT rs, input regAddrT rt,
		input regAddrT rd, input logic [4:0] sa);
	return {opSpecial, rs, rt, rd, sa, fn};
endfunction

function automatic dataT encodeI(input logic [5:0] op, input regAddrT rs, input regAddrT rt,
		input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic dataT randomInstr();
	logic [15:0] kind;
	logic [15:0] imm;
	logic [15:0] sa;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	kind = takeBits(4);
	rs = pickReg();
	rt = pickReg();
	rd = pickReg();
	imm = takeBits(16);
	sa = takeBits(5);
	case (kind[3:0])
		4'd0, 4'd11: return encodeR(fnAddu, rs, rt, rd, 5'd0);
		4'd1: return encodeR(fnSubu, rs, rt, rd, 5'd0);
		4'd2: return encodeR(fnAnd, rs, rt, rd, 5'd0);
		4'd3: return encodeR(fnOr, rs, rt, rd, 5'd0);
		4'd4: return encodeR(fnXor, rs, rt, rd, 5'd0);
		4'd5, 4'd12: return encodeR(fnSlt, rs, rt, rd, 5'd0);
		4'd6: return encodeR(fnSll, 5'd0, rt, rd, sa[4:0]);
		4'd7, 4'd10: return encodeI(opAddiu, rs, rt, imm);
		4'd8, 4'd15: return encodeI(opOri, rs, rt, imm);
		4'd9: return encodeI(opLui, 5'd0, rt, imm);
		// LW is outside the subset
		4'd13: return encodeI(6'h23, rs, rt, imm);
		// MULT
		default: return encodeR(6'h18, rs, rt, rd, 5'd0);
	endcase
endfunction

// In-order reference execution of one ROM slot
function automatic void retireGolden(input logic [5:0] idx);
	dataT ins;
	dataT a;
	dataT b;
	dataT result;
	logic [15:0] imm;
	regAddrT dest;
	logic writes;
	ins = rom[idx];
	imm = ins[15:0];
	a = goldRegs[ins[25:21]];
	b = goldRegs[ins[20:16]];
	dest = ins[20:16];
	result = '0;
	writes = 1'b1;
	case (ins[31:26])
		opSpecial: begin
			dest = ins[15:11];
			case (ins[5:0])
				fnAddu: result = a + b;
				fnSubu: result = a - b;
				fnAnd: result = a & b;
				fnOr: result = a | b;
				fnXor: result = a ^ b;
				fnSlt: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				fnSll: result = b << ins[10:6];
				default: writes = 1'b0;
			endcase
		end
		opAddiu: result = a + {{16{imm[15]}}, imm};
		opOri: result = a | {16'h0000, imm};
		opLui: result = {imm, 16'h0000};
		default: writes = 1'b0;
	endcase
	if (dest == 5'd0) begin
		writes = 1'b0;
	end
	goldWen[idx] = writes;
	goldDest[idx] = dest;
	goldData[idx] = result;
	if (writes) begin
		goldRegs[dest] = result;
	end
endfunction

`endif

// ==== cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

	logic clk = 1'b0;
	logic reset_i;
	logic instSramEn_o;
	dataT instSramAddr_o;
	dataT instSramRdata_i = '0;
	dataT debugWbPc_o;
	logic [3:0] debugWbRfWen_o;
	regAddrT debugWbRfWnum_o;
	dataT debugWbRfWdata_o;

	logic [15:0] lfsr = 16'd33957;
	dataT rom [0:63];
	dataT goldRegs [0:31];
	logic goldWen [0:63];
	regAddrT goldDest [0:63];
	dataT goldData [0:63];

	// Fetch index carried down alongside the DUT pipe
	dataT fetchCount;
	logic s1Valid;
	logic s2Valid;
	logic s3Valid;
	dataT s1Idx;
	dataT s2Idx;
	dataT s3Idx;
	logic primed = 1'b0;
	logic postReset = 1'b0;
	int retireCount = 0;
	int writeCount = 0;
	int waitCycles;
	int resetErrors = 0;
	int fetchErrors = 0;
	int retireErrors = 0;
	int dataErrors = 0;
	logic inProgram;
	logic expWen;
	dataT expPc;
	regAddrT expDest;
	dataT expData;

	`include "tbProgram.svh"

	// Past the 64-word program the ROM reads as SLL $0
	function automatic dataT romWord(input dataT addr);
		dataT offset;
		offset = addr - resetPc;
		if (offset[31:8] == 24'd0) begin
			return rom[offset[7:2]];
		end
		return '0;
	endfunction

	cpuTop UUT (
		.clk(clk),
		.reset_i(reset_i),
		.instSramEn_o(instSramEn_o),
		.instSramAddr_o(instSramAddr_o),
		.instSramRdata_i(instSramRdata_i),
		.debugWbPc_o(debugWbPc_o),
		.debugWbRfWen_o(debugWbRfWen_o),
		.debugWbRfWnum_o(debugWbRfWnum_o),
		.debugWbRfWdata_o(debugWbRfWdata_o)
	);

	always #2 clk = ~clk;

	always @(posedge clk) begin
		if (instSramEn_o) begin
			instSramRdata_i <= romWord(instSramAddr_o);
		end
	end

	always @(posedge clk) begin
		primed <= 1'b1;
		postReset <= reset_i;
		if (reset_i) begin
			fetchCount <= '0;
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
			s3Valid <= 1'b0;
			retireCount <= 0;
			writeCount <= 0;
		end else begin
			if (instSramEn_o) begin
				fetchCount <= fetchCount + 32'd1;
			end
			s1Valid <= instSramEn_o;
			s1Idx <= fetchCount;
			s2Valid <= s1Valid;
			s2Idx <= s1Idx;
			s3Valid <= s2Valid;
			s3Idx <= s2Idx;
			if (s3Valid && inProgram) begin
				retireCount <= retireCount + 1;
				if (expWen) begin
					writeCount <= writeCount + 1;
				end
			end
		end
	end

	assign inProgram = (s3Idx < 32'd64);
	assign expPc = resetPc + {s3Idx[29:0], 2'b00};
	assign expWen = inProgram && goldWen[s3Idx[5:0]];
	assign expDest = goldDest[s3Idx[5:0]];
	assign expData = goldData[s3Idx[5:0]];

	resetQuiet: assert property (@(posedge clk) primed && (reset_i || postReset) |->
		!instSramEn_o && debugWbRfWen_o == 4'b0000)
		else begin
			resetErrors++;
			$display("** Error: instSramEn_o = %h, debugWbRfWen_o = %h, expected 0 and 0",
				$sampled(instSramEn_o), $sampled(debugWbRfWen_o));
		end

	fetchOrder: assert property (@(posedge clk) disable iff (reset_i)
		instSramEn_o |-> instSramAddr_o == resetPc + {fetchCount[29:0], 2'b00})
		else begin
			fetchErrors++;
			$display("** Error: instSramAddr_o = %h, expected %h", $sampled(instSramAddr_o),
				resetPc + {$sampled(fetchCount[29:0]), 2'b00});
		end

	fetchSteady: assert property (@(posedge clk) disable iff (reset_i)
		fetchCount != 32'd0 |-> instSramEn_o)
		else begin
			fetchErrors++;
			$display("Fetch stopped after %0d words", $sampled(fetchCount));
		end

	retirePc: assert property (@(posedge clk) disable iff (reset_i)
		s3Valid |-> debugWbPc_o == expPc)
		else begin
			retireErrors++;
			$display("** Error: debugWbPc_o = %h, expected %h", $sampled(debugWbPc_o),
				$sampled(expPc));
		end

	retireWen: assert property (@(posedge clk) disable iff (reset_i)
		s3Valid |-> debugWbRfWen_o == (expWen ? wenAll : 4'b0000))
		else begin
			retireErrors++;
			$display("** Error: debugWbRfWen_o = %h, expected %h", $sampled(debugWbRfWen_o),
				$sampled(expWen) ? wenAll : 4'b0000);
		end

	// Bubbles must not write
	idleWen: assert property (@(posedge clk) disable iff (reset_i)
		!s3Valid |-> debugWbRfWen_o == 4'b0000)
		else begin
			retireErrors++;
			$display("** Error: debugWbRfWen_o = %h, expected 0 with nothing retiring",
				$sampled(debugWbRfWen_o));
		end

	retireNum: assert property (@(posedge clk) disable iff (reset_i)
		s3Valid && expWen |-> debugWbRfWnum_o == expDest)
		else begin
			dataErrors++;
			$display("** Error: debugWbRfWnum_o = %h, expected %h", $sampled(debugWbRfWnum_o),
				$sampled(expDest));
		end

	retireData: assert property (@(posedge clk) disable iff (reset_i)
		s3Valid && expWen |-> debugWbRfWdata_o == expData)
		else begin
			dataErrors++;
			$display("** Error: debugWbRfWdata_o = %h, expected %h", $sampled(debugWbRfWdata_o),
				$sampled(expData));
		end

	initial begin
		reset_i = 1'b1;
		for (int i = 0; i < 32; i++) begin
			goldRegs[i[4:0]] = '0;
		end
		for (int i = 0; i < 64; i++) begin
			rom[i[5:0]] = randomInstr();
		end
		for (int i = 0; i < 64; i++) begin
			retireGolden(i[5:0]);
		end
		repeat (4) @(posedge clk);
		reset_i <= 1'b0;
		waitCycles = 0;
		while (retireCount < 64 && waitCycles < 400) begin
			@(posedge clk);
			waitCycles++;
		end
		// Two spare edges for the last retirement checks
		repeat (2) @(posedge clk);
		if (retireCount < 64) begin
			$display("Timed out after %0d cycles with %0d of 64 instructions retired",
				waitCycles, retireCount);
		end
		$display("Retired %0d, writes %0d, errors: reset %0d fetch %0d retire %0d data %0d",
			retireCount, writeCount, resetErrors, fetchErrors, retireErrors, dataErrors);
		if (retireCount == 64 && resetErrors + fetchErrors + retireErrors + dataErrors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// ==== cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; (
	input logic clk,
	input logic reset_i,
	output logic instSramEn_o,
	output dataT instSramAddr_o,
	input dataT instSramRdata_i,
	output dataT debugWbPc_o,
	output logic [3:0] debugWbRfWen_o,
	output regAddrT debugWbRfWnum_o,
	output dataT debugWbRfWdata_o
);

	dataT pcD;
	logic fetchValid;
	regAddrT rsAddr;
	regAddrT rtAddr;
	dataT rsData;
	dataT rtData;
	logic exValid;
	aluOpT exAluOp;
	dataT exOperandA;
	dataT exOperandB;
	logic [4:0] exShamt;
	regAddrT exDest;
	logic exRegWrite;
	dataT exPc;
	dataT aluResult;
	dataT wbData;
	regAddrT wbDest;
	logic wbRegWrite;

	fetchUnit fetch (
		.clk(clk),
		.reset_i(reset_i),
		.instSramEn_o(instSramEn_o),
		.instSramAddr_o(instSramAddr_o),
		.pcD_o(pcD),
		.fetchValid_o(fetchValid)
	);

	decodeUnit decode (
		.clk(clk),
		.reset_i(reset_i),
		.instr_i(instSramRdata_i),
		.pcD_i(pcD),
		.fetchValid_i(fetchValid),
		.aluResult_i(aluResult),
		.exDest_i(exDest),
		.exRegWrite_i(exRegWrite),
		.wbData_i(wbData),
		.wbDest_i(wbDest),
		.wbRegWrite_i(wbRegWrite),
		.rsAddr_o(rsAddr),
		.rtAddr_o(rtAddr),
		.rsData_i(rsData),
		.rtData_i(rtData),
		.exValid_o(exValid),
		.exAluOp_o(exAluOp),
		.exOperandA_o(exOperandA),
		.exOperandB_o(exOperandB),
		.exShamt_o(exShamt),
		.exDest_o(exDest),
		.exRegWrite_o(exRegWrite),
		.exPc_o(exPc)
	);

	regFile regs (
		.clk(clk),
		.reset_i(reset_i),
		.rsAddr_i(rsAddr),
		.rtAddr_i(rtAddr),
		.rsData_o(rsData),
		.rtData_o(rtData),
		.writeEnable_i(wbRegWrite),
		.writeAddr_i(wbDest),
		.writeData_i(wbData)
	);

	executeUnit execute (
		.clk(clk),
		.reset_i(reset_i),
		.exValid_i(exValid),
		.exAluOp_i(exAluOp),
		.exOperandA_i(exOperandA),
		.exOperandB_i(exOperandB),
		.exShamt_i(exShamt),
		.exDest_i(exDest),
		.exRegWrite_i(exRegWrite),
		.exPc_i(exPc),
		.aluResult_o(aluResult),
		.wbData_o(wbData),
		.wbDest_o(wbDest),
		.wbRegWrite_o(wbRegWrite),
		.debugWbPc_o(debugWbPc_o),
		.debugWbRfWen_o(debugWbRfWen_o),
		.debugWbRfWnum_o(debugWbRfWnum_o),
		.debugWbRfWdata_o(debugWbRfWdata_o)
	);

endmodule

// ==== decodeUnit.sv ====
`timescale 1ns/1ps

module decodeUnit import cpuPkg::*; (
	input logic clk,
	input logic reset_i,
	input dataT instr_i,
	input dataT pcD_i,
	input logic fetchValid_i,
	input dataT aluResult_i,
	input regAddrT exDest_i,
	input logic exRegWrite_i,
	input dataT wbData_i,
	input regAddrT wbDest_i,
	input logic wbRegWrite_i,
	output regAddrT rsAddr_o,
	output regAddrT rtAddr_o,
	input dataT rsData_i,
	input dataT rtData_i,
	output logic exValid_o,
	output aluOpT exAluOp_o,
	output dataT exOperandA_o,
	output dataT exOperandB_o,
	output logic [4:0] exShamt_o,
	output regAddrT exDest_o,
	output logic exRegWrite_o,
	output dataT exPc_o
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic [15:0] imm;
	regAddrT rs;
	regAddrT rt;
	regAddrT rd;
	regAddrT dest;
	aluOpT aluOp;
	logic known;
	logic useImm;
	logic destRd;
	logic zeroExt;
	dataT immExt;
	dataT srcA;
	dataT srcB;

	assign opcode = instr_i[31:26];
	assign rs = instr_i[25:21];
	assign rt = instr_i[20:16];
	assign rd = instr_i[15:11];
	assign funct = instr_i[5:0];
	assign imm = instr_i[15:0];

	always_comb begin
		aluOp = aluNone;
		known = 1'b0;
		useImm = 1'b0;
		destRd = 1'b0;
		zeroExt = 1'b0;
		case (opcode)
			opSpecial: begin
				destRd = 1'b1;
				known = 1'b1;
				case (funct)
					fnAddu: aluOp = aluAdd;
					fnSubu: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnOr: aluOp = aluOr;
					fnXor: aluOp = aluXor;
					fnSlt: aluOp = aluSlt;
					fnSll: aluOp = aluSll;
					default: known = 1'b0;
				endcase
			end
			opAddiu: begin
				aluOp = aluAdd;
				known = 1'b1;
				useImm = 1'b1;
			end
			opOri: begin
				aluOp = aluOr;
				known = 1'b1;
				useImm = 1'b1;
				zeroExt = 1'b1;
			end
			opLui: begin
				// Execute moves the low half up
				aluOp = aluLui;
				known = 1'b1;
				useImm = 1'b1;
				zeroExt = 1'b1;
			end
			default: ;
		endcase
	end

	assign dest = destRd ? rd : rt;
	assign immExt = zeroExt ? {16'h0000, imm} : {{16{imm[15]}}, imm};

	// Youngest producer wins; $0 is never forwarded
	always_comb begin
		if (rs != 5'd0 && exRegWrite_i && exDest_i == rs) begin
			srcA = aluResult_i;
		end else if (rs != 5'd0 && wbRegWrite_i && wbDest_i == rs) begin
			srcA = wbData_i;
		end else begin
			srcA = rsData_i;
		end
		if (rt != 5'd0 && exRegWrite_i && exDest_i == rt) begin
			srcB = aluResult_i;
		end else if (rt != 5'd0 && wbRegWrite_i && wbDest_i == rt) begin
			srcB = wbData_i;
		end else begin
			srcB = rtData_i;
		end
	end

	assign rsAddr_o = rs;
	assign rtAddr_o = rt;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			exValid_o <= 1'b0;
			exRegWrite_o <= 1'b0;
			exAluOp_o <= aluNone;
		end else begin
			exValid_o <= fetchValid_i;
			exRegWrite_o <= fetchValid_i && known && dest != 5'd0;
			exAluOp_o <= known ? aluOp : aluNone;
		end
	end

	always_ff @(posedge clk) begin
		exOperandA_o <= srcA;
		exOperandB_o <= useImm ? immExt : srcB;
		exShamt_o <= instr_i[10:6];
		exDest_o <= dest;
		exPc_o <= pcD_i;
	end

endmodule

// ==== executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit import cpuPkg::*; (
	input logic clk,
	input logic reset_i,
	input logic exValid_i,
	input aluOpT exAluOp_i,
	input dataT exOperandA_i,
	input dataT exOperandB_i,
	input logic [4:0] exShamt_i,
	input regAddrT exDest_i,
	input logic exRegWrite_i,
	input dataT exPc_i,
	output dataT aluResult_o,
	output dataT wbData_o,
	output regAddrT wbDest_o,
	output logic wbRegWrite_o,
	output dataT debugWbPc_o,
	output logic [3:0] debugWbRfWen_o,
	output regAddrT debugWbRfWnum_o,
	output dataT debugWbRfWdata_o
);

	dataT wbPc;

	always_comb begin
		case (exAluOp_i)
			aluAdd: aluResult_o = exOperandA_i + exOperandB_i;
			aluSub: aluResult_o = exOperandA_i - exOperandB_i;
			aluAnd: aluResult_o = exOperandA_i & exOperandB_i;
			aluOr: aluResult_o = exOperandA_i | exOperandB_i;
			aluXor: aluResult_o = exOperandA_i ^ exOperandB_i;
			aluSlt: aluResult_o = {31'b0, $signed(exOperandA_i) < $signed(exOperandB_i)};
			aluSll: aluResult_o = exOperandB_i << exShamt_i;
			aluLui: aluResult_o = {exOperandB_i[15:0], 16'h0000};
			default: aluResult_o = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset_i) begin
			wbRegWrite_o <= 1'b0;
		end else begin
			wbRegWrite_o <= exValid_i && exRegWrite_i;
		end
	end

	always_ff @(posedge clk) begin
		wbData_o <= aluResult_o;
		wbDest_o <= exDest_i;
		wbPc <= exPc_i;
	end

	// Trace port of the retiring instruction
	assign debugWbPc_o = wbPc;
	assign debugWbRfWen_o = wbRegWrite_o ? wenAll : 4'b0000;
	assign debugWbRfWnum_o = wbDest_o;
	assign debugWbRfWdata_o = wbData_o;

	// Decode only requests a write for a valid instruction
	writeNeedsValid: assert property (@(posedge clk) disable iff (reset_i)
		exRegWrite_i |-> exValid_i)
		else $error("register write requested by an invalid instruction in execute");

endmodule

// ==== fetchUnit.sv ====
`timescale 1ns/1ps

module fetchUnit import cpuPkg::*; (
	input logic clk,
	input logic reset_i,
	output logic instSramEn_o,
	output dataT instSramAddr_o,
	output dataT pcD_o,
	output logic fetchValid_o
);

	dataT pc;
	logic fetchEn;

	// Enable comes up one cycle after reset is released
	always_ff @(posedge clk) begin
		if (reset_i) begin
			fetchEn <= 1'b0;
			pc <= resetPc;
			fetchValid_o <= 1'b0;
		end else begin
			fetchEn <= 1'b1;
			fetchValid_o <= fetchEn;
			if (fetchEn) begin
				pc <= pc + 32'd4;
			end
		end
	end

	// Address of the word the SRAM returns this cycle
	always_ff @(posedge clk) begin
		pcD_o <= pc;
	end

	assign instSramEn_o = fetchEn;
	assign instSramAddr_o = pc;

endmodule

// ==== filelist.f ====
+incdir+.
cpuPkg.sv
fetchUnit.sv
regFile.sv
decodeUnit.sv
executeUnit.sv
cpuTop.sv
cpuTb.sv

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
	input logic clk,
	input logic reset_i,
	input regAddrT rsAddr_i,
	input regAddrT rtAddr_i,
	output dataT rsData_o,
	output dataT rtData_o,
	input logic writeEnable_i,
	input regAddrT writeAddr_i,
	input dataT writeData_i
);

	// No storage behind $0
	dataT regs [1:31];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i[4:0]] <= '0;
			end
		end else if (writeEnable_i && writeAddr_i != 5'd0) begin
			regs[writeAddr_i] <= writeData_i;
		end
	end

	assign rsData_o = (rsAddr_i == 5'd0) ? '0 : regs[rsAddr_i];
	assign rtData_o = (rtAddr_i == 5'd0) ? '0 : regs[rtAddr_i];

	// Decode drops writes to $0 before they reach writeback
	noZeroWrite: assert property (@(posedge clk) disable iff (reset_i)
		writeEnable_i |-> writeAddr_i != 5'd0)
		else $error("register file write to $0");

endmodule

// ==== runSim.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --timescale 1ns/1ps --top-module cpuTb \
		-f filelist.f -o cpuSim > build.log 2>&1 \
	&& ./obj_dir/cpuSim > sim.log 2>&1 \
	|| { echo "build or simulation run failed"; tail -n 40 build.log; exit 1; }
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; tail -n 40 sim.log; exit 1; }
